// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_debug_irq_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_debug_irq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module tb_debug_irq_top
  import dmi_pkg::*;
  import irq_pkg::*;
();

  localparam int unsigned Holdoff = 20;
  localparam int KindDmi  = 0;
  localparam int KindPins = 1;
  localparam int KindHold = 2;

  typedef struct {
    string      name;
    int         kind;
    logic       sel;
    dtm_op_e    op;
    dmi_addr_t  addr;
    dmi_data_t  wdata;
    logic [3:0] irq;
    logic       en;
    dmi_resp_e  exp_code;
    dmi_data_t  exp_data;
    logic       exp_dbg;
    logic       exp_ndm;
  } row_t;

  logic      clk_i, rst_ni, jtag_sel_i, debug_enable_i;
  logic      msip_i, mtip_i, seip_i, meip_i;
  logic      jtag_req_valid_i, jtag_req_ready_o, jtag_resp_valid_o, jtag_resp_ready_i;
  logic      dtm_req_valid_i, dtm_req_ready_o, dtm_resp_valid_o, dtm_resp_ready_i;
  dmi_addr_t jtag_req_addr_i, dtm_req_addr_i;
  dtm_op_e   jtag_req_op_i, dtm_req_op_i;
  dmi_data_t jtag_req_data_i, dtm_req_data_i;
  dmi_data_t resp_data_o;
  dmi_resp_e resp_code_o;
  logic      debug_req_o, ndmreset_o;
  mip_vec_t  mip_o;
  clic_src_t clic_src_o;

  row_t      rows[$];
  bit        table_ready = 1'b0;
  int        seed = 32'h5c5d_97f0;
  int        edge_cnt;

  debug_irq_top #(.HoldoffCycles(Holdoff)) dut_i (.*);

  always #2 clk_i = ~clk_i;

  // rising edges since reset release
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // no debug request may reach the hart before the hold-off ends
  always @(negedge clk_i) begin
    if (rst_ni && edge_cnt < Holdoff && debug_req_o !== 1'b0) begin
      fail_now($sformatf("debug request raised after only %0d edges", edge_cnt));
    end
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 40 + Holdoff + 50) @(posedge clk_i);
    fail_now("watchdog expired before all table rows completed");
  end

  task automatic check_resp(input string name, input dmi_resp_e exp_code,
                            input dmi_data_t exp_data, input dmi_resp_e act_code,
                            input dmi_data_t act_data);
    if (act_code !== exp_code || act_data !== exp_data) begin
      fail_now($sformatf("CHECK FAILED %s: expected code %0d data %h, actual code %0d data %h",
                         name, exp_code, exp_data, act_code, act_data));
    end
  endtask

  task automatic check_mip(input string name, input mip_vec_t exp, input mip_vec_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: expected mip %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_clic(input string name, input clic_src_t exp, input clic_src_t act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: expected clic %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // msip, mtip, seip, meip land on mip bits 3, 7, 9 and 11
  function automatic mip_vec_t mip_for(input logic [3:0] irq, input logic ndm);
    mip_vec_t m;
    m = '0;
    if (!ndm) begin
      m[3]  = irq[0];
      m[7]  = irq[1];
      m[9]  = irq[2];
      m[11] = irq[3];
    end
    return m;
  endfunction

  task automatic add_dmi(input string name, input logic sel, input dtm_op_e op,
                         input dmi_addr_t addr, input dmi_data_t wdata,
                         input dmi_resp_e code, input dmi_data_t data);
    row_t r;
    r = '{name, KindDmi, sel, op, addr, wdata, 4'h0, 1'b1, code, data, 1'b0, 1'b0};
    rows.push_back(r);
  endtask

  task automatic add_pins(input string name, input logic [3:0] irq, input logic en,
                          input logic dbg, input logic ndm);
    row_t r;
    r = '{name, KindPins, 1'b0, DTM_NOP, '0, '0, irq, en, DTM_SUCCESS, '0, dbg, ndm};
    rows.push_back(r);
  endtask

  task automatic add_hold(input string name);
    row_t r;
    r = '{name, KindHold, 1'b0, DTM_NOP, '0, '0, 4'h0, 1'b1, DTM_SUCCESS, '0, 1'b1, 1'b0};
    rows.push_back(r);
  endtask

  task automatic check_deselected(input string name, input logic sel);
    check_bit({name, "_other_req_ready"}, 1'b0, sel ? dtm_req_ready_o : jtag_req_ready_o);
    check_bit({name, "_other_resp_valid"}, 1'b0, sel ? dtm_resp_valid_o : jtag_resp_valid_o);
  endtask

  // one DMI transfer with a random hold on resp_ready
  task automatic run_dmi(input row_t r);
    int unsigned bp;
    logic        seen;
    bp = $unsigned($random(seed)) % 4;
    // source select settles a cycle before the request starts
    jtag_sel_i = r.sel;
    @(negedge clk_i);
    jtag_req_valid_i = r.sel;
    dtm_req_valid_i  = !r.sel;
    jtag_req_addr_i  = r.addr;
    dtm_req_addr_i   = r.addr;
    jtag_req_op_i    = r.op;
    dtm_req_op_i     = r.op;
    jtag_req_data_i  = r.wdata;
    dtm_req_data_i   = r.wdata;
    seen = 1'b0;
    while (!seen) begin
      seen = r.sel ? jtag_req_ready_o : dtm_req_ready_o;
      check_deselected(r.name, r.sel);
      @(negedge clk_i);
    end
    jtag_req_valid_i = 1'b0;
    dtm_req_valid_i  = 1'b0;
    seen = 1'b0;
    while (!seen) begin
      seen = r.sel ? jtag_resp_valid_o : dtm_resp_valid_o;
      check_deselected(r.name, r.sel);
      if (!seen) begin
        @(negedge clk_i);
      end
    end
    check_resp(r.name, r.exp_code, r.exp_data, resp_code_o, resp_data_o);
    repeat (bp) @(negedge clk_i);
    check_bit({r.name, "_held_valid"}, 1'b1, r.sel ? jtag_resp_valid_o : dtm_resp_valid_o);
    check_resp({r.name, "_held"}, r.exp_code, r.exp_data, resp_code_o, resp_data_o);
    jtag_resp_ready_i = r.sel;
    dtm_resp_ready_i  = !r.sel;
    @(negedge clk_i);
    jtag_resp_ready_i = 1'b0;
    dtm_resp_ready_i  = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // stimulus table
  // --------------------------------------------------------------------------
  task automatic build_table();
    dmi_data_t rnd_a;
    dmi_data_t rnd_b;
    rnd_a = $random(seed);
    rnd_b = $random(seed);
    add_dmi("dmctl_halt", 1'b0, DTM_WRITE, `DM_DMCONTROL_ADDR, 32'h8000_0001,
            DTM_SUCCESS, '0);
    add_hold("holdoff_release");
    add_pins("dbg_disabled", 4'h0, 1'b0, 1'b0, 1'b0);
    add_pins("dbg_enabled", 4'h0, 1'b1, 1'b1, 1'b0);
    add_dmi("data0_wr", 1'b0, DTM_WRITE, `DM_DATA0_ADDR, rnd_a, DTM_SUCCESS, '0);
    add_dmi("data0_rd", 1'b0, DTM_READ, `DM_DATA0_ADDR, '0, DTM_SUCCESS, rnd_a);
    add_dmi("unmapped_rd", 1'b0, DTM_READ, 7'h22, '0, DTM_SUCCESS, '0);
    add_dmi("unmapped_wr", 1'b0, DTM_WRITE, 7'h30, rnd_b, DTM_SUCCESS, '0);
    add_dmi("nop", 1'b0, DTM_NOP, `DM_DATA0_ADDR, rnd_b, DTM_SUCCESS, '0);
    add_dmi("rsvd_op", 1'b0, DTM_RSVD, `DM_DATA0_ADDR, rnd_b, DTM_FAILED, '0);
    add_dmi("data0_kept", 1'b0, DTM_READ, `DM_DATA0_ADDR, '0, DTM_SUCCESS, rnd_a);
    add_dmi("dmctl_rd", 1'b0, DTM_READ, `DM_DMCONTROL_ADDR, '0, DTM_SUCCESS, 32'h8000_0001);
    add_dmi("jtag_wr", 1'b1, DTM_WRITE, `DM_DATA0_ADDR, rnd_b, DTM_SUCCESS, '0);
    add_dmi("jtag_rd", 1'b1, DTM_READ, `DM_DATA0_ADDR, '0, DTM_SUCCESS, rnd_b);
    for (int i = 0; i < 16; i++) begin
      add_pins($sformatf("irq_combo_%0d", i), 4'(i), 1'b1, 1'b1, 1'b0);
    end
    add_dmi("ndm_set", 1'b0, DTM_WRITE, `DM_DMCONTROL_ADDR, 32'h8000_0003, DTM_SUCCESS, '0);
    add_pins("ndm_masks_irq", 4'hf, 1'b1, 1'b1, 1'b1);
    add_dmi("dm_deactivate", 1'b0, DTM_WRITE, `DM_DMCONTROL_ADDR, '0, DTM_SUCCESS, '0);
    add_pins("dm_off", 4'hf, 1'b1, 1'b0, 1'b0);
    add_dmi("data0_cleared", 1'b0, DTM_READ, `DM_DATA0_ADDR, '0, DTM_SUCCESS, '0);
  endtask

  initial begin
    mip_vec_t exp_mip;
    clic_src_t exp_clic;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    jtag_sel_i = 1'b0;
    debug_enable_i = 1'b1;
    {meip_i, seip_i, mtip_i, msip_i} = 4'h0;
    {jtag_req_valid_i, jtag_resp_ready_i, dtm_req_valid_i, dtm_resp_ready_i} = 4'h0;
    jtag_req_addr_i = '0;
    dtm_req_addr_i = '0;
    jtag_req_op_i = DTM_NOP;
    dtm_req_op_i = DTM_NOP;
    jtag_req_data_i = '0;
    dtm_req_data_i = '0;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    check_bit("reset_req_ready", 1'b1, dtm_req_ready_o);
    check_bit("reset_resp_valid", 1'b0, dtm_resp_valid_o);
    check_bit("reset_ndmreset", 1'b0, ndmreset_o);
    foreach (rows[i]) begin
      debug_enable_i = rows[i].en;
      {meip_i, seip_i, mtip_i, msip_i} = rows[i].irq;
      if (rows[i].kind == KindDmi) begin
        run_dmi(rows[i]);
      end else if (rows[i].kind == KindHold) begin
        if (edge_cnt >= Holdoff) begin
          fail_now("halt request write completed only after the hold-off window");
        end
        while (edge_cnt < Holdoff) @(negedge clk_i);
        check_bit(rows[i].name, rows[i].exp_dbg, debug_req_o);
      end else begin
        @(negedge clk_i);
        exp_mip = mip_for(rows[i].irq, rows[i].exp_ndm);
        exp_clic = '0;
        exp_clic[`XLEN-1:0] = exp_mip;
        check_mip(rows[i].name, exp_mip, mip_o);
        check_clic(rows[i].name, exp_clic, clic_src_o);
        check_bit({rows[i].name, "_debug_req"}, rows[i].exp_dbg, debug_req_o);
        check_bit({rows[i].name, "_ndmreset"}, rows[i].exp_ndm, ndmreset_o);
      end
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/boot_holdoff.sv
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module boot_holdoff #(
  parameter int unsigned Cycles = `HOLDOFF_CYCLES
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic holdoff_active_o
);

  localparam int unsigned CntW = $clog2(Cycles + 1);

  logic [CntW-1:0] cnt_q;

  // loaded by reset, counts down once and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(Cycles);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign holdoff_active_o = (cnt_q != '0);

  a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CntW'(Cycles))
    else $error("boot_holdoff: count above Cycles");

endmodule

`default_nettype wire

// File: rtl/debug_irq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module debug_irq_top
  import dmi_pkg::*;
  import irq_pkg::*;
#(
  parameter int unsigned HoldoffCycles = `HOLDOFF_CYCLES
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      jtag_sel_i,
  input  logic      debug_enable_i,
  input  logic      msip_i,
  input  logic      mtip_i,
  input  logic      seip_i,
  input  logic      meip_i,
  // JTAG side DMI
  input  logic      jtag_req_valid_i,
  output logic      jtag_req_ready_o,
  input  dmi_addr_t jtag_req_addr_i,
  input  dtm_op_e   jtag_req_op_i,
  input  dmi_data_t jtag_req_data_i,
  output logic      jtag_resp_valid_o,
  input  logic      jtag_resp_ready_i,
  // DTM side DMI
  input  logic      dtm_req_valid_i,
  output logic      dtm_req_ready_o,
  input  dmi_addr_t dtm_req_addr_i,
  input  dtm_op_e   dtm_req_op_i,
  input  dmi_data_t dtm_req_data_i,
  output logic      dtm_resp_valid_o,
  input  logic      dtm_resp_ready_i,
  output dmi_data_t resp_data_o,
  output dmi_resp_e resp_code_o,
  // hart side
  output logic      debug_req_o,
  output logic      ndmreset_o,
  output mip_vec_t  mip_o,
  output clic_src_t clic_src_o
);

  logic haltreq;
  logic ndmreset;
  logic holdoff_active;

  assign ndmreset_o = ndmreset;

  dm_ctrl i_dm_ctrl (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_req_addr_i   ( jtag_req_addr_i   ),
    .jtag_req_op_i     ( jtag_req_op_i     ),
    .jtag_req_data_i   ( jtag_req_data_i   ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_req_addr_i    ( dtm_req_addr_i    ),
    .dtm_req_op_i      ( dtm_req_op_i      ),
    .dtm_req_data_i    ( dtm_req_data_i    ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .resp_data_o       ( resp_data_o       ),
    .resp_code_o       ( resp_code_o       ),
    .haltreq_o         ( haltreq           ),
    .ndmreset_o        ( ndmreset          )
  );

  // keeps debug away from the hart while boot code runs
  boot_holdoff #(
    .Cycles ( HoldoffCycles )
  ) i_boot_holdoff (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .holdoff_active_o ( holdoff_active )
  );

  hart_event_gate i_hart_event_gate (
    .haltreq_i        ( haltreq        ),
    .holdoff_active_i ( holdoff_active ),
    .ndmreset_i       ( ndmreset       ),
    .debug_enable_i   ( debug_enable_i ),
    .msip_i           ( msip_i         ),
    .mtip_i           ( mtip_i         ),
    .seip_i           ( seip_i         ),
    .meip_i           ( meip_i         ),
    .debug_req_o      ( debug_req_o    ),
    .mip_o            ( mip_o          ),
    .clic_src_o       ( clic_src_o     )
  );

endmodule

`default_nettype wire

// File: rtl/dm_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "harness_defines.svh"

module dm_ctrl
  import dmi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      jtag_sel_i,
  // JTAG side DMI
  input  logic      jtag_req_valid_i,
  output logic      jtag_req_ready_o,
  input  dmi_addr_t jtag_req_addr_i,
  input  dtm_op_e   jtag_req_op_i,
  input  dmi_data_t jtag_req_data_i,
  output logic      jtag_resp_valid_o,
  input  logic      jtag_resp_ready_i,
  // DTM side DMI
  input  logic      dtm_req_valid_i,
  output logic      dtm_req_ready_o,
  input  dmi_addr_t dtm_req_addr_i,
  input  dtm_op_e   dtm_req_op_i,
  input  dmi_data_t dtm_req_data_i,
  output logic      dtm_resp_valid_o,
  input  logic      dtm_resp_ready_i,
  // response payload, shared by both sources
  output dmi_data_t resp_data_o,
  output dmi_resp_e resp_code_o,
  output logic      haltreq_o,
  output logic      ndmreset_o
);

  logic       req_valid;
  logic       req_ready;
  dmi_addr_t  req_addr;
  dtm_op_e    req_op;
  dmi_data_t  req_data;
  logic       resp_ready;

  // accepted request, executed one edge later
  logic       pend_q;
  dmi_addr_t  addr_q;
  dtm_op_e    op_q;
  dmi_data_t  wdata_q;

  logic       resp_valid_q;
  dmi_data_t  resp_data_q;
  dmi_resp_e  resp_code_q;
  dmi_data_t  resp_data_d;
  dmi_resp_e  resp_code_d;

  dmi_data_t  data0_q;
  dmcontrol_t dmcontrol_q;
  dmi_word_u  wword;
  logic       wr_data0;
  logic       wr_dmcontrol;

  // ------------------------------------------------------------------------
  // source select
  // ------------------------------------------------------------------------
  assign req_valid  = jtag_sel_i ? jtag_req_valid_i  : dtm_req_valid_i;
  assign req_addr   = jtag_sel_i ? jtag_req_addr_i   : dtm_req_addr_i;
  assign req_op     = jtag_sel_i ? jtag_req_op_i     : dtm_req_op_i;
  assign req_data   = jtag_sel_i ? jtag_req_data_i   : dtm_req_data_i;
  assign resp_ready = jtag_sel_i ? jtag_resp_ready_i : dtm_resp_ready_i;

  // one transaction in flight
  assign req_ready = ~(pend_q | resp_valid_q);

  assign jtag_req_ready_o  = jtag_sel_i & req_ready;
  assign dtm_req_ready_o   = ~jtag_sel_i & req_ready;
  assign jtag_resp_valid_o = jtag_sel_i & resp_valid_q;
  assign dtm_resp_valid_o  = ~jtag_sel_i & resp_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      pend_q <= req_valid & req_ready;
      if (pend_q) begin
        resp_valid_q <= 1'b1;
      end else if (resp_ready) begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid && req_ready) begin
      addr_q  <= req_addr;
      op_q    <= req_op;
      wdata_q <= req_data;
    end
    if (pend_q) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  // ------------------------------------------------------------------------
  // register file
  // ------------------------------------------------------------------------
  assign wword.raw    = wdata_q;
  assign wr_data0     = pend_q && (op_q == DTM_WRITE) && (addr_q == `DM_DATA0_ADDR);
  assign wr_dmcontrol = pend_q && (op_q == DTM_WRITE) && (addr_q == `DM_DMCONTROL_ADDR);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data0_q     <= '0;
      dmcontrol_q <= '0;
    end else if (wr_dmcontrol) begin
      if (wword.dmcontrol.dmactive) begin
        dmcontrol_q.haltreq  <= wword.dmcontrol.haltreq;
        dmcontrol_q.ndmreset <= wword.dmcontrol.ndmreset;
        dmcontrol_q.dmactive <= 1'b1;
      end else begin
        // inactive DM drops everything
        dmcontrol_q <= '0;
        data0_q     <= '0;
      end
    end else if (wr_data0) begin
      data0_q <= wdata_q;
    end
  end

  // read data and code for the latched request
  always_comb begin
    resp_data_d = '0;
    resp_code_d = DTM_SUCCESS;
    case (op_q)
      DTM_READ: begin
        if (addr_q == `DM_DATA0_ADDR) begin
          resp_data_d = data0_q;
        end else if (addr_q == `DM_DMCONTROL_ADDR) begin
          resp_data_d = dmcontrol_q;
        end
      end
      DTM_RSVD: resp_code_d = DTM_FAILED;
      default: ;
    endcase
  end

  assign resp_data_o = resp_data_q;
  assign resp_code_o = resp_code_q;
  assign haltreq_o   = dmcontrol_q.haltreq;
  assign ndmreset_o  = dmcontrol_q.ndmreset;

  // held response must not move until the source takes it
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (resp_valid_q && !resp_ready) |=> ($stable(resp_data_o) && $stable(resp_code_o)))
    else $error("dm_ctrl: response changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/dmi_pkg.sv
`default_nettype none

`include "harness_defines.svh"

package dmi_pkg;

  typedef logic [`DMI_ADDR_W-1:0] dmi_addr_t;
  typedef logic [`DMI_DATA_W-1:0] dmi_data_t;

  // request op as carried on the DMI
  typedef enum logic [1:0] {
    DTM_NOP   = 2'd0,
    DTM_READ  = 2'd1,
    DTM_WRITE = 2'd2,
    DTM_RSVD  = 2'd3
  } dtm_op_e;

  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'd0,
    DTM_FAILED  = 2'd2,
    DTM_BUSY    = 2'd3
  } dmi_resp_e;

  // subset of the debug spec dmcontrol layout
  typedef struct packed {
    logic        haltreq;
    logic        resumereq;
    logic [27:0] zero0;
    logic        ndmreset;
    logic        dmactive;
  } dmcontrol_t;

  // one DMI word, seen raw or as dmcontrol
  typedef union packed {
    dmi_data_t  raw;
    dmcontrol_t dmcontrol;
  } dmi_word_u;

endpackage

`default_nettype wire

// File: rtl/harness_defines.svh
`ifndef HARNESS_DEFINES_SVH
`define HARNESS_DEFINES_SVH

// DMI transport widths
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// hart register width and CLIC source count
`define XLEN         64
`define CLIC_NUM_SRC 256

// cycles from reset release until the hart may see a debug request
`define HOLDOFF_CYCLES 500

// ------------------------------------------------------------------------
// debug module register map
// ------------------------------------------------------------------------
`define DM_DATA0_ADDR     7'h04
`define DM_DMCONTROL_ADDR 7'h10

`endif

// File: rtl/hart_event_gate.sv
`timescale 1ns/1ps
`default_nettype none

module hart_event_gate
  import irq_pkg::*;
(
  input  logic      haltreq_i,
  input  logic      holdoff_active_i,
  input  logic      ndmreset_i,
  input  logic      debug_enable_i,
  input  logic      msip_i,
  input  logic      mtip_i,
  input  logic      seip_i,
  input  logic      meip_i,
  output logic      debug_req_o,
  output mip_vec_t  mip_o,
  output clic_src_t clic_src_o
);

  mip_vec_t mip_raw;

  // ------------------------------------------------------------------------
  // debug request
  // ------------------------------------------------------------------------
  // blocked during boot hold-off and when debug is disabled
  assign debug_req_o = haltreq_i & ~holdoff_active_i & debug_enable_i;

  // ------------------------------------------------------------------------
  // interrupt vectors
  // ------------------------------------------------------------------------
  always_comb begin
    mip_raw           = '0;
    mip_raw[IRQ_MSIP] = msip_i;
    mip_raw[IRQ_MTIP] = mtip_i;
    mip_raw[IRQ_SEIP] = seip_i;
    mip_raw[IRQ_MEIP] = meip_i;
  end

  // nothing reaches the hart while ndmreset is held
  assign mip_o = ndmreset_i ? '0 : mip_raw;

  // mip causes take the low CLIC sources, the rest are platform lines
  assign clic_src_o = {{($bits(clic_src_t) - $bits(mip_vec_t)){1'b0}}, mip_o};

  always_comb begin
    a_req_enabled: assert final (!debug_req_o || debug_enable_i)
      else $error("hart_event_gate: debug request while disabled");
  end

endmodule

`default_nettype wire

// File: rtl/irq_pkg.sv
`default_nettype none

`include "harness_defines.svh"

package irq_pkg;

  // mip-style pending vector, one bit per interrupt cause
  typedef logic [`XLEN-1:0] mip_vec_t;

  // local interrupt lines into the CLIC
  typedef logic [`CLIC_NUM_SRC-1:0] clic_src_t;

  // cause positions inside mip
  typedef enum int unsigned {
    IRQ_MSIP = 3,
    IRQ_MTIP = 7,
    IRQ_SEIP = 9,
    IRQ_MEIP = 11
  } irq_bit_e;

endpackage

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/dmi_pkg.sv
rtl/irq_pkg.sv
rtl/dm_ctrl.sv
rtl/boot_holdoff.sv
rtl/hart_event_gate.sv
rtl/debug_irq_top.sv
dv/tb_debug_irq_top.sv
